// File: all.f
common/bnn_pkg.sv
common/layer_link_if.sv
first_layer/feature_capture.sv
first_layer/first_layer.sv
source/output_neuron.sv
source/class_select.sv
source/bnn_top.sv
test/bnn_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = bnn_tb
FILELIST = all.f

BUILD   = obj_dir
SIM     = $(BUILD)/V$(TOP)
LOG     = sim.log
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes.
$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: test/bnn_tb.sv
`timescale 1ns/10ps
`default_nettype none

module bnn_tb;

  localparam int FW      = bnn_pkg::FEAT_CNT * bnn_pkg::FEAT_BITS;
  localparam int H       = bnn_pkg::HIDDEN_CNT;
  localparam int CB      = bnn_pkg::CLASS_BITS;
  localparam int TIMEOUT = 200; // cycles per wait.

  logic          clk = 1'b0;
  logic          rst;
  logic          in_req;
  logic          in_ack;
  logic [FW-1:0] features;
  logic          out_req;
  logic          out_ack;
  logic [CB-1:0] class_idx;
  logic [H-1:0]  hidden;

  logic [15:0]     lfsr = 16'd15;
  logic [H+CB-1:0] expect_q [$]; // {hidden, class} in send order.
  int              errors = 0;
  int              taken = 0;    // finished output handshakes.
  int              passed = 0;
  int              failed = 0;
  logic            p_in_req;
  logic            p_in_ack;
  logic            p_out_req;
  logic            p_out_ack;
  logic [CB-1:0]   p_class;
  logic [H-1:0]    p_hidden;

  bnn_top UUT (
    .clk       (clk),
    .rst       (rst),
    .in_req    (in_req),
    .in_ack    (in_ack),
    .features  (features),
    .out_req   (out_req),
    .out_ack   (out_ack),
    .class_idx (class_idx),
    .hidden    (hidden)
  );

  always #10 clk = ~clk;

  // ########################################
  // stimulus and reference model
  // ########################################
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1); // taps 16,14,13,11.
  endfunction

  task automatic random_vector(output logic [FW-1:0] v);
    v = '0;
    for (int b = 0; b < FW; b++) begin
      v    = {v[FW-2:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  function automatic logic [H-1:0] model_hidden(input logic [FW-1:0] f);
    logic [H-1:0] h;
    int           sum;
    int           x;
    for (int k = 0; k < H; k++) begin
      sum = 0;
      for (int i = 0; i < bnn_pkg::FEAT_CNT; i++) begin
        x   = int'(f[i*bnn_pkg::FEAT_BITS +: bnn_pkg::FEAT_BITS]);
        sum = bnn_pkg::L1_WEIGHTS[k*bnn_pkg::FEAT_CNT+i] ? sum + x : sum - x;
      end
      h[k] = (sum >= 0); // zero counts as positive.
    end
    return h;
  endfunction

  function automatic logic [CB-1:0] model_class(input logic [H-1:0] h);
    logic [CB-1:0] best;
    int            best_score;
    int            score;
    best       = '0;
    best_score = -1;
    for (int c = 0; c < bnn_pkg::CLASS_CNT; c++) begin
      score = 0;
      for (int k = 0; k < H; k++) begin
        if (h[k] == bnn_pkg::L2_WEIGHTS[c*H+k]) score++;
      end
      if (score > best_score) begin // first maximum keeps ties.
        best_score = score;
        best       = c[CB-1:0];
      end
    end
    return best;
  endfunction

  task automatic check_true(input logic ok, input string what);
    assert (ok) else begin
      $display("%s", what);
      errors++;
    end
  endtask

  task automatic check_value(input string name, input int got, input int want);
    assert (got == want) else begin
      $display("ERROR %s got 0x%0h expected 0x%0h", name, got, want);
      errors++;
    end
  endtask

  // ########################################
  // handshake drivers
  // ########################################
  task automatic send_vector(input logic [FW-1:0] f, output int taken_at_ack);
    logic [H-1:0] h;
    int           t;
    h = model_hidden(f);
    expect_q.push_back({h, model_class(h)});
    @(posedge clk);
    features <= f;
    in_req   <= 1'b1;
    for (t = 0; t < TIMEOUT && !in_ack; t++) @(posedge clk);
    check_true(in_ack, "timeout waiting for in_ack to rise");
    taken_at_ack = taken;
    in_req <= 1'b0;
    for (t = 0; t < TIMEOUT && in_ack; t++) @(posedge clk);
    check_true(!in_ack, "timeout waiting for in_ack to fall");
  endtask

  task automatic receive_result(input int hold, output logic [H-1:0] hid);
    logic [H+CB-1:0] want;
    int              t;
    want = '0;
    for (t = 0; t < TIMEOUT && !out_req; t++) @(posedge clk);
    check_true(out_req, "timeout waiting for out_req to rise");
    check_true(expect_q.size() > 0, "a result came out with no vector pending");
    if (expect_q.size() > 0) want = expect_q.pop_front();
    hid = hidden;
    check_value("hidden", int'(hidden), int'(want[H+CB-1:CB]));
    check_value("class_idx", int'(class_idx), int'(want[CB-1:0]));
    repeat (hold) @(posedge clk);
    out_ack <= 1'b1;
    for (t = 0; t < TIMEOUT && out_req; t++) @(posedge clk);
    check_true(!out_req, "timeout waiting for out_req to fall");
    out_ack <= 1'b0;
    taken++;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      passed++;
      $display("test %s: passed", name);
    end else begin
      failed++;
      $display("test %s: failed with %0d errors", name, errors - errs_before);
    end
  endtask

  // protocol order and output stability.
  always @(posedge clk) begin
    if (!rst) begin
      if (in_ack && !p_in_ack) check_true(p_in_req, "in_ack rose while in_req was low");
      if (!in_ack && p_in_ack) check_true(!p_in_req, "in_ack fell while in_req was high");
      if (!out_req && p_out_req) check_true(p_out_ack, "out_req fell before out_ack rose");
      if (out_req && !p_out_req) begin
        check_true(!p_out_ack, "out_req rose while out_ack was high");
      end
      if (out_req && p_out_req) begin
        check_value("class_idx", int'(class_idx), int'(p_class));
        check_value("hidden", int'(hidden), int'(p_hidden));
      end
    end
    p_in_req  <= in_req;
    p_in_ack  <= in_ack;
    p_out_req <= out_req;
    p_out_ack <= out_ack;
    p_class   <= class_idx;
    p_hidden  <= hidden;
  end

  // ########################################
  // test sequence
  // ########################################
  initial begin
    logic [FW-1:0] f;
    logic [H-1:0]  hid;
    int            mark;
    int            at_ack;
    int            base;
    rst      = 1'b1;
    in_req   = 1'b0;
    out_ack  = 1'b0;
    features = '0;

    mark = errors;
    repeat (10) begin
      @(posedge clk);
      check_true(!in_ack && !out_req, "in_ack or out_req high during reset");
    end
    rst <= 1'b0;
    repeat (5) begin
      @(posedge clk);
      check_true(!in_ack && !out_req, "in_ack or out_req high after reset");
    end
    finish_test("reset state", mark);

    mark = errors;
    for (int n = 0; n < 20; n++) begin
      random_vector(f);
      send_vector(f, at_ack);
      receive_result(0, hid);
    end
    send_vector('0, at_ack);
    receive_result(0, hid);
    check_value("hidden", int'(hid), int'({H{1'b1}}));
    finish_test("first layer", mark);

    // each L2 row holds four ones, so a zero vector ties all classes.
    mark = errors;
    send_vector('0, at_ack);
    receive_result(0, hid);
    for (int n = 0; n < 8; n++) begin
      random_vector(f);
      send_vector(f, at_ack);
      receive_result(1, hid);
    end
    finish_test("classification", mark);

    mark = errors;
    fork
      begin
        for (int n = 0; n < 6; n++) begin
          random_vector(f);
          send_vector(f, at_ack);
        end
      end
      begin
        for (int n = 0; n < 6; n++) receive_result(n, hid);
      end
    join
    finish_test("handshake order", mark);

    mark = errors;
    base = taken;
    fork
      begin
        repeat (3) begin
          random_vector(f);
          send_vector(f, at_ack);
        end
        check_true(at_ack > base, "third in_ack came before the first result was taken");
      end
      begin
        receive_result(40, hid);
        receive_result(0, hid);
        receive_result(0, hid);
      end
    join
    finish_test("back-pressure", mark);

    $display("%0d tests passed, %0d failed, %0d errors", passed, failed, errors);
    if (failed == 0 && errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/bnn_top.sv
`timescale 1ns/10ps
`default_nettype none

module bnn_top (
  input  wire logic                                            clk,
  input  wire logic                                            rst,
  input  wire logic                                            in_req,
  output      logic                                            in_ack,
  input  wire logic [bnn_pkg::FEAT_CNT*bnn_pkg::FEAT_BITS-1:0] features,
  output      logic                                            out_req,
  input  wire logic                                            out_ack,
  output      logic [bnn_pkg::CLASS_BITS-1:0]                  class_idx,
  output      logic [bnn_pkg::HIDDEN_CNT-1:0]                  hidden
);

  layer_link_if link ();

  logic [bnn_pkg::SCORE_BITS-1:0] scores [bnn_pkg::CLASS_CNT];

  feature_capture u_capture (
    .clk      (clk),
    .rst      (rst),
    .in_req   (in_req),
    .in_ack   (in_ack),
    .features (features),
    .link     (link)
  );

  first_layer u_layer (
    .clk  (clk),
    .rst  (rst),
    .link (link)
  );

  // one neuron per class, each with its own weight row.
  for (genvar c = 0; c < bnn_pkg::CLASS_CNT; c++) begin : g_class
    output_neuron #(
      .WEIGHT_ROW (bnn_pkg::L2_WEIGHTS[c*bnn_pkg::HIDDEN_CNT +: bnn_pkg::HIDDEN_CNT])
    ) u_neuron (
      .hidden (link.hidden),
      .score  (scores[c])
    );
  end

  class_select u_select (
    .clk       (clk),
    .rst       (rst),
    .link      (link),
    .scores    (scores),
    .out_req   (out_req),
    .out_ack   (out_ack),
    .class_idx (class_idx),
    .hidden    (hidden)
  );

endmodule

`default_nettype wire

// File: source/class_select.sv
`timescale 1ns/10ps
`default_nettype none

module class_select (
  input  wire logic                           clk,
  input  wire logic                           rst,
  layer_link_if.sink                          link,
  input  wire logic [bnn_pkg::SCORE_BITS-1:0] scores [bnn_pkg::CLASS_CNT],
  output      logic                           out_req,
  input  wire logic                           out_ack,
  output      logic [bnn_pkg::CLASS_BITS-1:0] class_idx,
  output      logic [bnn_pkg::HIDDEN_CNT-1:0] hidden
);

  logic [bnn_pkg::CLASS_BITS-1:0] best_idx;
  logic [bnn_pkg::SCORE_BITS-1:0] best_score;
  logic                           grab;

  // ########################################
  // argmax
  // ########################################
  always_comb begin
    best_idx   = '0;
    best_score = scores[0];
    for (int c = 1; c < bnn_pkg::CLASS_CNT; c++) begin
      if (scores[c] > best_score) begin // strict, ties keep lower index.
        best_score = scores[c];
        best_idx   = c[bnn_pkg::CLASS_BITS-1:0];
      end
    end
  end

  // only when the previous output cycle is fully closed.
  assign grab = link.done && !out_req && !out_ack;

  // ########################################
  // output handshake
  // ########################################
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_req   <= 1'b0;
      link.take <= 1'b0;
    end else begin
      link.take <= grab;
      if (grab) begin
        out_req <= 1'b1;
      end else if (out_ack) begin
        out_req <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (grab) begin
      class_idx <= best_idx;
      hidden    <= link.hidden;
    end
  end

endmodule

`default_nettype wire

// File: source/output_neuron.sv
`timescale 1ns/10ps
`default_nettype none

module output_neuron #(
  parameter logic [bnn_pkg::HIDDEN_CNT-1:0] WEIGHT_ROW = '0
) (
  input  wire logic [bnn_pkg::HIDDEN_CNT-1:0] hidden,
  output      logic [bnn_pkg::SCORE_BITS-1:0] score
);

  logic [bnn_pkg::HIDDEN_CNT-1:0] agree;

  assign agree = hidden ~^ WEIGHT_ROW; // 1 where signs match.

  // popcount.
  always_comb begin
    score = '0;
    for (int k = 0; k < bnn_pkg::HIDDEN_CNT; k++) begin
      score = score + {{(bnn_pkg::SCORE_BITS-1){1'b0}}, agree[k]};
    end
  end

endmodule

`default_nettype wire

// File: first_layer/first_layer.sv
`timescale 1ns/10ps
`default_nettype none

module first_layer (
  input wire logic   clk,
  input wire logic   rst,
  layer_link_if.layer link
);

  logic [bnn_pkg::HIDDEN_CNT:0]   marker;   // top bit set means done.
  logic [bnn_pkg::HIDDEN_CNT-1:0] active;
  logic                           running;
  logic [bnn_pkg::FEAT_CNT-1:0]   row;
  logic [bnn_pkg::SUM_BITS-1:0]   neg_cnt;
  logic [bnn_pkg::SUM_BITS-1:0]   sum;
  logic                           neuron_bit;
  logic [bnn_pkg::HIDDEN_CNT-1:0] hidden_q;

  // neuron 0 is worked out in the start cycle itself.
  assign active  = link.start ? {{(bnn_pkg::HIDDEN_CNT-1){1'b0}}, 1'b1}
                              : marker[bnn_pkg::HIDDEN_CNT-1:0];
  assign running = |active;

  // ########################################
  // row select
  // ########################################
  always_comb begin
    row     = '0;
    neg_cnt = '0;
    for (int k = bnn_pkg::HIDDEN_CNT - 1; k >= 0; k--) begin
      if (active[k]) begin // lowest marked row wins.
        row     = bnn_pkg::L1_WEIGHTS[k*bnn_pkg::FEAT_CNT +: bnn_pkg::FEAT_CNT];
        neg_cnt = bnn_pkg::L1_NEG_CNT[k*bnn_pkg::SUM_BITS +: bnn_pkg::SUM_BITS];
      end
    end
  end

  // ########################################
  // dot product
  // ########################################
  // -x is ~x + 1, so the +1s come in once as neg_cnt.
  always_comb begin
    sum = neg_cnt;
    for (int i = 0; i < bnn_pkg::FEAT_CNT; i++) begin
      sum = sum + ({bnn_pkg::SUM_BITS{row[i]}} ~^
                   {{(bnn_pkg::SUM_BITS-bnn_pkg::FEAT_BITS){1'b0}},
                    link.features[i*bnn_pkg::FEAT_BITS +: bnn_pkg::FEAT_BITS]});
    end
  end

  assign neuron_bit = ~sum[bnn_pkg::SUM_BITS-1]; // sum >= 0.

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      marker <= '0;
    end else if (running) begin
      marker <= {active, 1'b0};
    end else if (link.take) begin
      marker <= '0; // back to idle.
    end
  end

  // neuron 0 ends up in bit 0 after the last shift.
  always_ff @(posedge clk) begin
    if (running) begin
      hidden_q <= {neuron_bit, hidden_q[bnn_pkg::HIDDEN_CNT-1:1]};
    end
  end

  assign link.hidden = hidden_q;
  assign link.done   = marker[bnn_pkg::HIDDEN_CNT];

endmodule

`default_nettype wire

// File: first_layer/feature_capture.sv
`timescale 1ns/10ps
`default_nettype none

module feature_capture (
  input  wire logic                                            clk,
  input  wire logic                                            rst,
  input  wire logic                                            in_req,
  output      logic                                            in_ack,
  input  wire logic [bnn_pkg::FEAT_CNT*bnn_pkg::FEAT_BITS-1:0] features,
  layer_link_if.src                                            link
);

  logic busy;   // layer holds a result not yet taken.
  logic accept;

  assign accept = in_req && !in_ack && !busy;

  // ########################################
  // input handshake
  // ########################################
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      in_ack     <= 1'b0;
      link.start <= 1'b0;
      busy       <= 1'b0;
    end else begin
      link.start <= accept;
      if (accept) begin
        in_ack <= 1'b1;
      end else if (!in_req) begin
        in_ack <= 1'b0;
      end
      if (accept) begin
        busy <= 1'b1;
      end else if (link.take && link.done) begin
        busy <= 1'b0; // layer freed.
      end
    end
  end

  // features stay put for the whole layer run.
  always_ff @(posedge clk) begin
    if (accept) begin
      link.features <= features;
    end
  end

endmodule

`default_nettype wire

// File: common/layer_link_if.sv
`timescale 1ns/10ps
`default_nettype none

interface layer_link_if;

  logic [bnn_pkg::FEAT_CNT*bnn_pkg::FEAT_BITS-1:0] features;
  logic                                            start; // one cycle pulse.
  logic [bnn_pkg::HIDDEN_CNT-1:0]                  hidden;
  logic                                            done;  // level until take.
  logic                                            take;  // one cycle pulse.

  modport src (
    output features,
    output start,
    input  done,
    input  take
  );

  // take is seen here so done can drop.
  modport layer (
    input  features,
    input  start,
    input  take,
    output hidden,
    output done
  );

  modport sink (
    input  hidden,
    input  done,
    output take
  );

endinterface

`default_nettype wire

// File: common/bnn_pkg.sv
`default_nettype none

package bnn_pkg;

  // ########################################
  // network sizes
  // ########################################
  localparam int FEAT_CNT   = 4;
  localparam int FEAT_BITS  = 4;
  localparam int HIDDEN_CNT = 8;
  localparam int CLASS_CNT  = 4;
  localparam int CLASS_BITS = 2;
  localparam int SCORE_BITS = 4; // holds 0..HIDDEN_CNT.
  localparam int SUM_BITS   = 7; // signed, 4 terms of 4 bits.

  // ########################################
  // weights, 1 is +1 and 0 is -1
  // ########################################
  // bit k*FEAT_CNT+i: feature i to hidden k.
  localparam logic [HIDDEN_CNT*FEAT_CNT-1:0] L1_WEIGHTS = 32'h6C35_A19E;

  // bit c*HIDDEN_CNT+k: hidden k to class c.
  localparam logic [CLASS_CNT*HIDDEN_CNT-1:0] L2_WEIGHTS = 32'hB42D_E117;

  // number of -1 weights per first layer row.
  function automatic logic [HIDDEN_CNT*SUM_BITS-1:0] neg_counts(
    input logic [HIDDEN_CNT*FEAT_CNT-1:0] w
  );
    logic [HIDDEN_CNT*SUM_BITS-1:0] tbl;
    logic [SUM_BITS-1:0] cnt;
    tbl = '0;
    for (int k = 0; k < HIDDEN_CNT; k++) begin
      cnt = '0;
      for (int i = 0; i < FEAT_CNT; i++) begin
        if (!w[k*FEAT_CNT+i]) cnt = cnt + 1'b1;
      end
      tbl[k*SUM_BITS +: SUM_BITS] = cnt;
    end
    return tbl;
  endfunction

  localparam logic [HIDDEN_CNT*SUM_BITS-1:0] L1_NEG_CNT = neg_counts(L1_WEIGHTS);

endpackage

`default_nettype wire
